/* hw/vec_pkg.sv */
`default_nettype none

// shared widths, instruction layout and opcode encoding for the vector sequencer
package vec_pkg;

    // element address width, also the width of the vector length
    localparam int rf_addr_width = 8;

    // number of elements in the flat register file
    localparam int rf_depth = 1 << rf_addr_width;

    // one register-file element
    localparam int elem_width = 32;

    // instruction word
    localparam int instr_width = 32;

    // opcode field width
    localparam int op_width = 4;

    // low bit of each instruction field
    // opcode [31:28], vd [27:20], vs1 [19:12], vs2/imm [11:4]
    // bits [3:0] carry nothing
    localparam int op_lsb  = 28;
    localparam int vd_lsb  = 20;
    localparam int vs1_lsb = 12;
    localparam int vs2_lsb = 4;

    // opcode values
    typedef enum logic [op_width-1:0] {
        op_nop        = 4'd0,
        op_vsetivli   = 4'd1,
        op_vle32      = 4'd2,
        op_vse32      = 4'd3,
        op_vmacc      = 4'd4,
        op_vstreamout = 4'd5
    } vec_op_e;

endpackage

`default_nettype wire

/* hw/vec_op_if.sv */
`timescale 1ns/10ps
`default_nettype none

// decoded operation from the decoder to the sequencer
// everything here follows instr combinationally
interface vec_op_if;

    // one-hot operation flags, all low for nop
    logic is_vsetivli;
    logic is_vle32_v;
    logic is_vse32_v;
    logic is_vmacc_vv;
    logic is_vstreamout;

    // base addresses taken from vs1, vs2 and vd
    logic [vec_pkg::rf_addr_width-1:0] vr_addr1;
    logic [vec_pkg::rf_addr_width-1:0] vr_addr2;
    logic [vec_pkg::rf_addr_width-1:0] vw_addr;

    // vs2 field read as a vector length for vsetivli
    logic [vec_pkg::rf_addr_width-1:0] imm_vl;

    // decoder side
    modport dec (
        output is_vsetivli, is_vle32_v, is_vse32_v, is_vmacc_vv, is_vstreamout,
        output vr_addr1, vr_addr2, vw_addr, imm_vl
    );

    // sequencer side
    modport seq (
        input is_vsetivli, is_vle32_v, is_vse32_v, is_vmacc_vv, is_vstreamout,
        input vr_addr1, vr_addr2, vw_addr, imm_vl
    );

endinterface

`default_nettype wire

/* hw/vrf_port_if.sv */
`timescale 1ns/10ps
`default_nettype none

// element addresses and write strobe from the sequencer to the register file
interface vrf_port_if;

    // read addresses for the two read ports
    logic [vec_pkg::rf_addr_width-1:0] rd_addr1;
    logic [vec_pkg::rf_addr_width-1:0] rd_addr2;

    // write address and strobe, one element per cycle with wr_en high
    logic [vec_pkg::rf_addr_width-1:0] wr_addr;
    logic                              wr_en;

    // sequencer side
    modport seq (
        output rd_addr1, rd_addr2, wr_addr, wr_en
    );

    // register file side
    modport rf (
        input rd_addr1, rd_addr2, wr_addr, wr_en
    );

endinterface

`default_nettype wire

/* hw/vec_decode.sv */
`timescale 1ns/10ps
`default_nettype none

// instruction decoder
// purely combinational, splits the word into flags, base addresses and the immediate
module vec_decode (
    input  logic [vec_pkg::instr_width-1:0] instr,
    vec_op_if.dec                           op
);

    // raw opcode field, cast so the case below reads by name
    vec_pkg::vec_op_e opcode;

    assign opcode = vec_pkg::vec_op_e'(instr[vec_pkg::op_lsb +: vec_pkg::op_width]);

    // one flag per known opcode
    always_comb begin
        op.is_vsetivli   = 1'b0;
        op.is_vle32_v    = 1'b0;
        op.is_vse32_v    = 1'b0;
        op.is_vmacc_vv   = 1'b0;
        op.is_vstreamout = 1'b0;
        case (opcode)
            vec_pkg::op_vsetivli: begin
                op.is_vsetivli = 1'b1;
            end
            vec_pkg::op_vle32: begin
                op.is_vle32_v = 1'b1;
            end
            vec_pkg::op_vse32: begin
                op.is_vse32_v = 1'b1;
            end
            vec_pkg::op_vmacc: begin
                op.is_vmacc_vv = 1'b1;
            end
            vec_pkg::op_vstreamout: begin
                op.is_vstreamout = 1'b1;
            end
            default: begin
                // nop and unused codes raise nothing
                op.is_vsetivli = 1'b0;
            end
        endcase
    end

    // vs1 is the first read base
    assign op.vr_addr1 = instr[vec_pkg::vs1_lsb +: vec_pkg::rf_addr_width];

    // vs2 is the second read base
    assign op.vr_addr2 = instr[vec_pkg::vs2_lsb +: vec_pkg::rf_addr_width];

    // vd is the write base
    assign op.vw_addr = instr[vec_pkg::vd_lsb +: vec_pkg::rf_addr_width];

    // same bits as vs2, used as the new length by vsetivli
    assign op.imm_vl = instr[vec_pkg::vs2_lsb +: vec_pkg::rf_addr_width];

endmodule

`default_nettype wire

/* hw/auto_incr_vect.sv */
`timescale 1ns/10ps
`default_nettype none

// element address sequencer
// one start per new pc holding a vector op, then base plus counter on each side
module auto_incr_vect (
    input  logic                              clk,
    input  logic                              rst,
    vec_op_if.seq                             op,
    input  logic                              load_pc,
    input  logic                              incr_pc,
    input  logic                              stall_rd,
    input  logic                              stall_wr,
    output logic [vec_pkg::rf_addr_width-1:0] vl,
    output logic                              wen_itr,
    output logic                              rd_valid,
    output logic                              done,
    vrf_port_if.seq                           rf
);

    // per-side state, idle until a start, counting until the final step
    typedef enum logic {
        st_idle,
        st_count
    } seq_state_e;

    logic pc_pulse;
    logic armed;
    logic is_vect;
    logic is_rd_op;
    logic is_wr_op;

    // index of the final element, vl of zero is never used
    logic [vec_pkg::rf_addr_width-1:0] last_idx;

    seq_state_e                        rd_state;
    logic [vec_pkg::rf_addr_width-1:0] rd_cnt;
    logic                              rd_active;
    logic                              rd_step;
    logic                              rd_last;

    seq_state_e                        wr_state;
    logic [vec_pkg::rf_addr_width-1:0] wr_cnt;
    logic                              wr_active;
    logic                              wr_step;
    logic                              wr_last;

    assign pc_pulse = load_pc | incr_pc;

    // vsetivli is not a sequenced op, it never starts the counters
    assign is_rd_op = op.is_vse32_v | op.is_vstreamout | op.is_vmacc_vv;
    assign is_wr_op = op.is_vle32_v | op.is_vmacc_vv;
    assign is_vect  = is_rd_op | is_wr_op;

    // vector length register
    always_ff @(posedge clk) begin
        if (rst) begin
            vl <= '0;
        end else if (op.is_vsetivli) begin
            vl <= op.imm_vl;
        end
    end

    assign last_idx = vl - 1'b1;

    // start gate
    // armed by a pc pulse, disarmed by the start it lets through
    // a held instruction after done therefore cannot restart
    always_ff @(posedge clk) begin
        if (rst) begin
            armed <= 1'b0;
        end else if (pc_pulse) begin
            armed <= 1'b1;
        end else if (wen_itr) begin
            armed <= 1'b0;
        end
    end

    assign wen_itr = armed & is_vect;

    // read side
    // active in the start cycle already, so step 0 can go out with wen_itr
    assign rd_active = (rd_state == st_count) | (wen_itr & is_rd_op);
    assign rd_step   = rd_active & ~stall_rd;
    assign rd_last   = rd_step & (rd_cnt == last_idx);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= st_idle;
            rd_cnt   <= '0;
        end else if (rd_last || done) begin
            // done closes the op on both sides
            rd_state <= st_idle;
            rd_cnt   <= '0;
        end else if (rd_step) begin
            rd_state <= st_count;
            rd_cnt   <= rd_cnt + 1'b1;
        end else if (rd_active) begin
            // stalled start, keep the count at 0 and wait
            rd_state <= st_count;
        end
    end

    // write side, same scheme under stall_wr
    assign wr_active = (wr_state == st_count) | (wen_itr & is_wr_op);
    assign wr_step   = wr_active & ~stall_wr;
    assign wr_last   = wr_step & (wr_cnt == last_idx);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= st_idle;
            wr_cnt   <= '0;
        end else if (wr_last || done) begin
            wr_state <= st_idle;
            wr_cnt   <= '0;
        end else if (wr_step) begin
            wr_state <= st_count;
            wr_cnt   <= wr_cnt + 1'b1;
        end else if (wr_active) begin
            wr_state <= st_count;
        end
    end

    // strobes, low while the matching side is stalled
    assign rd_valid = rd_step;
    assign rf.wr_en = wr_step;

    // final write step ends ops that write, final read step ends pure reads
    assign done = wr_last | (rd_last & ~op.is_vmacc_vv);

    // vmacc keeps vs1 as a fixed operand, vs2 walks with the read count
    assign rf.rd_addr1 = op.is_vmacc_vv ? op.vr_addr1 : op.vr_addr1 + rd_cnt;
    assign rf.rd_addr2 = op.vr_addr2 + rd_cnt;
    assign rf.wr_addr  = op.vw_addr + wr_cnt;

endmodule

`default_nettype wire

/* hw/vec_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

// flat element register file
// two combinational read ports, one synchronous write port
module vec_regfile (
    input  logic                           clk,
    input  logic                           rst,
    vrf_port_if.rf                         port,
    input  logic [vec_pkg::elem_width-1:0] wr_data,
    output logic [vec_pkg::elem_width-1:0] rd_data1,
    output logic [vec_pkg::elem_width-1:0] rd_data2
);

    // element storage, contents survive reset
    logic [vec_pkg::elem_width-1:0] mem [vec_pkg::rf_depth];

    // write at the rising edge, visible to the reads one cycle later
    // writes are held off while the core is in reset
    always_ff @(posedge clk) begin
        if (port.wr_en && !rst) begin
            mem[port.wr_addr] <= wr_data;
        end
    end

    // reads follow the addresses directly
    // so the data lines up with rd_valid in the same cycle
    assign rd_data1 = mem[port.rd_addr1];
    assign rd_data2 = mem[port.rd_addr2];

endmodule

`default_nettype wire

/* hw/vec_addr_seq_top.sv */
`timescale 1ns/10ps
`default_nettype none

// top level of the vector address sequencer
// decoder, sequencer and register file joined through two interfaces
module vec_addr_seq_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [vec_pkg::instr_width-1:0]   instr,
    input  logic                              load_pc,
    input  logic                              incr_pc,
    input  logic                              stall_rd,
    input  logic                              stall_wr,
    input  logic [vec_pkg::elem_width-1:0]    wr_data,
    output logic [vec_pkg::rf_addr_width-1:0] vl,
    output logic                              wen_itr,
    output logic                              rd_valid,
    output logic                              done,
    output logic [vec_pkg::rf_addr_width-1:0] vr_addr1,
    output logic [vec_pkg::rf_addr_width-1:0] vr_addr2,
    output logic [vec_pkg::rf_addr_width-1:0] vw_addr,
    output logic                              wr_en,
    output logic [vec_pkg::elem_width-1:0]    rd_data1,
    output logic [vec_pkg::elem_width-1:0]    rd_data2
);

    // decoded op, decoder to sequencer
    vec_op_if op_bus ();

    // element addresses, sequencer to register file
    vrf_port_if rf_bus ();

    vec_decode u_decode (
        .instr (instr),
        .op    (op_bus)
    );

    auto_incr_vect u_seq (
        .clk      (clk),
        .rst      (rst),
        .op       (op_bus),
        .load_pc  (load_pc),
        .incr_pc  (incr_pc),
        .stall_rd (stall_rd),
        .stall_wr (stall_wr),
        .vl       (vl),
        .wen_itr  (wen_itr),
        .rd_valid (rd_valid),
        .done     (done),
        .rf       (rf_bus)
    );

    vec_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .port     (rf_bus),
        .wr_data  (wr_data),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2)
    );

    // sequenced addresses and strobe made visible at the pins
    assign vr_addr1 = rf_bus.rd_addr1;
    assign vr_addr2 = rf_bus.rd_addr2;
    assign vw_addr  = rf_bus.wr_addr;
    assign wr_en    = rf_bus.wr_en;

endmodule

`default_nettype wire

/* verif/tb_vec_addr_seq.sv */
`timescale 1ns/10ps
`default_nettype none

// testbench for the vector address sequencer
// a cycle model predicts every output and a negedge process compares
module tb_vec_addr_seq;

    // limit far above the roughly 100 cycles of the tests
    localparam int max_cycles = 2000;

    // expected outputs of one cycle plus the activity flags the model needs
    typedef struct packed {
        logic [vec_pkg::rf_addr_width-1:0] vl;
        logic                              wen_itr;
        logic                              rd_act;
        logic                              wr_act;
        logic                              rd_valid;
        logic                              wr_en;
        logic                              done;
        logic [vec_pkg::rf_addr_width-1:0] a1;
        logic [vec_pkg::rf_addr_width-1:0] a2;
        logic [vec_pkg::rf_addr_width-1:0] aw;
        logic [vec_pkg::elem_width-1:0]    d1;
        logic [vec_pkg::elem_width-1:0]    d2;
        logic                              d1_known;
        logic                              d2_known;
    } expect_t;

    logic                              clk = 1'b0;
    logic                              rst;
    logic [vec_pkg::instr_width-1:0]   instr;
    logic                              load_pc;
    logic                              incr_pc;
    logic                              stall_rd;
    logic                              stall_wr;
    logic [vec_pkg::elem_width-1:0]    wr_data;
    logic [vec_pkg::rf_addr_width-1:0] vl;
    logic                              wen_itr;
    logic                              rd_valid;
    logic                              done;
    logic [vec_pkg::rf_addr_width-1:0] vr_addr1;
    logic [vec_pkg::rf_addr_width-1:0] vr_addr2;
    logic [vec_pkg::rf_addr_width-1:0] vw_addr;
    logic                              wr_en;
    logic [vec_pkg::elem_width-1:0]    rd_data1;
    logic [vec_pkg::elem_width-1:0]    rd_data2;

    // model state as the DUT should hold it after the coming edge
    logic [vec_pkg::rf_addr_width-1:0] m_vl;
    logic                              m_armed;
    logic                              m_rd_busy;
    logic [vec_pkg::rf_addr_width-1:0] m_rd_n;
    logic                              m_wr_busy;
    logic [vec_pkg::rf_addr_width-1:0] m_wr_n;

    // shadow of the element storage
    // known marks the entries written so far
    logic [vec_pkg::elem_width-1:0] shadow [vec_pkg::rf_depth];
    logic                           known [vec_pkg::rf_depth];

    integer seed;
    int     cycle_count;
    int     wen_count;
    int     done_count;
    int     rd_steps;
    int     wr_steps;

    vec_addr_seq_top uut (
        .clk      (clk),
        .rst      (rst),
        .instr    (instr),
        .load_pc  (load_pc),
        .incr_pc  (incr_pc),
        .stall_rd (stall_rd),
        .stall_wr (stall_wr),
        .wr_data  (wr_data),
        .vl       (vl),
        .wen_itr  (wen_itr),
        .rd_valid (rd_valid),
        .done     (done),
        .vr_addr1 (vr_addr1),
        .vr_addr2 (vr_addr2),
        .vw_addr  (vw_addr),
        .wr_en    (wr_en),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            $display("error at time %0t: %s is %0h, expected %0h", $time, what, got, want);
            $display("** FAIL **");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // expected outputs from the current inputs and the model state
    function automatic expect_t predict_outputs();
        expect_t                           e;
        logic [vec_pkg::op_width-1:0]      opc;
        logic                              rd_op;
        logic                              wr_op;
        logic [vec_pkg::rf_addr_width-1:0] last;
        logic [vec_pkg::rf_addr_width-1:0] vs1;
        opc   = instr[vec_pkg::op_lsb +: vec_pkg::op_width];
        vs1   = instr[vec_pkg::vs1_lsb +: vec_pkg::rf_addr_width];
        rd_op = (opc == vec_pkg::op_vse32) || (opc == vec_pkg::op_vstreamout) ||
                (opc == vec_pkg::op_vmacc);
        wr_op = (opc == vec_pkg::op_vle32) || (opc == vec_pkg::op_vmacc);
        last  = m_vl - 1'b1;
        e.vl       = m_vl;
        // first decoded vector op after a pc pulse starts the sequence
        e.wen_itr  = m_armed && (rd_op || wr_op);
        e.rd_act   = m_rd_busy || (e.wen_itr && rd_op);
        e.wr_act   = m_wr_busy || (e.wen_itr && wr_op);
        e.rd_valid = e.rd_act && !stall_rd;
        e.wr_en    = e.wr_act && !stall_wr;
        // writing ops end on their last write and pure reads on their last read
        e.done     = wr_op ? (e.wr_en && m_wr_n == last) : (e.rd_valid && m_rd_n == last);
        e.a1       = (opc == vec_pkg::op_vmacc) ? vs1 : vs1 + m_rd_n;
        e.a2       = instr[vec_pkg::vs2_lsb +: vec_pkg::rf_addr_width] + m_rd_n;
        e.aw       = instr[vec_pkg::vd_lsb +: vec_pkg::rf_addr_width] + m_wr_n;
        e.d1       = shadow[e.a1];
        e.d2       = shadow[e.a2];
        e.d1_known = known[e.a1];
        e.d2_known = known[e.a2];
        return e;
    endfunction

    // move the model across the next rising edge
    task automatic advance_model(input expect_t e);
        logic rd_last;
        logic wr_last;
        rd_last = e.rd_valid && (m_rd_n == m_vl - 1'b1);
        wr_last = e.wr_en && (m_wr_n == m_vl - 1'b1);
        if (rst) begin
            m_vl      = '0;
            m_armed   = 1'b0;
            m_rd_busy = 1'b0;
            m_rd_n    = '0;
            m_wr_busy = 1'b0;
            m_wr_n    = '0;
        end else begin
            if (e.wr_en) begin
                shadow[e.aw] = wr_data;
                known[e.aw]  = 1'b1;
            end
            if (instr[vec_pkg::op_lsb +: vec_pkg::op_width] == vec_pkg::op_vsetivli) begin
                m_vl = instr[vec_pkg::vs2_lsb +: vec_pkg::rf_addr_width];
            end
            if (load_pc || incr_pc) begin
                m_armed = 1'b1;
            end else if (e.wen_itr) begin
                m_armed = 1'b0;
            end
            // done ends the whole op and a finished side also goes back to 0
            if (rd_last || e.done) begin
                m_rd_busy = 1'b0;
                m_rd_n    = '0;
            end else if (e.rd_act) begin
                m_rd_busy = 1'b1;
                m_rd_n    = m_rd_n + e.rd_valid;
            end
            if (wr_last || e.done) begin
                m_wr_busy = 1'b0;
                m_wr_n    = '0;
            end else if (e.wr_act) begin
                m_wr_busy = 1'b1;
                m_wr_n    = m_wr_n + e.wr_en;
            end
        end
    endtask

    // compare at the falling edge where inputs and outputs are settled
    initial begin : compare
        expect_t e;
        forever begin
            @(negedge clk);
            e = predict_outputs();
            if (!rst) begin
                check_value("vl", vl, e.vl);
                check_value("wen_itr", wen_itr, e.wen_itr);
                check_value("rd_valid", rd_valid, e.rd_valid);
                check_value("wr_en", wr_en, e.wr_en);
                check_value("done", done, e.done);
                check_value("vr_addr1", vr_addr1, e.a1);
                check_value("vr_addr2", vr_addr2, e.a2);
                check_value("vw_addr", vw_addr, e.aw);
                if (e.d1_known) begin
                    check_value("rd_data1", rd_data1, e.d1);
                end
                if (e.d2_known) begin
                    check_value("rd_data2", rd_data2, e.d2);
                end
                wen_count  = wen_count + wen_itr;
                done_count = done_count + done;
                rd_steps   = rd_steps + rd_valid;
                wr_steps   = wr_steps + wr_en;
            end
            advance_model(e);
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
            if (cycle_count >= max_cycles) begin
                $display("** FAIL **");
                $fatal(1, "timeout, the tests did not finish within %0d cycles", max_cycles);
            end
        end
    end

    // true with a chance of pct in 100
    function automatic logic chance(input int pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    function automatic logic [vec_pkg::instr_width-1:0] make_instr(
        input vec_pkg::vec_op_e opc, input logic [7:0] vd, input logic [7:0] vs1,
        input logic [7:0] vs2);
        logic [vec_pkg::instr_width-1:0] w;
        w = '0;
        w[vec_pkg::op_lsb +: vec_pkg::op_width]       = opc;
        w[vec_pkg::vd_lsb +: vec_pkg::rf_addr_width]  = vd;
        w[vec_pkg::vs1_lsb +: vec_pkg::rf_addr_width] = vs1;
        w[vec_pkg::vs2_lsb +: vec_pkg::rf_addr_width] = vs2;
        return w;
    endfunction

    // fetch word arrives one cycle after the pc pulse
    task automatic set_length(input logic [7:0] imm);
        @(posedge clk);
        load_pc <= 1'b1;
        @(posedge clk);
        load_pc <= 1'b0;
        instr   <= make_instr(vec_pkg::op_vsetivli, 8'h00, 8'h00, imm);
        @(posedge clk);
        instr <= make_instr(vec_pkg::op_nop, 8'h00, 8'h00, 8'h00);
        @(negedge clk);
        check_value("vl after vsetivli", vl, imm);
    endtask

    // one vector op under random stalls
    // exp_rd below 0 skips the read count
    task automatic run_op(input logic [vec_pkg::instr_width-1:0] word, input int rd_pct,
                          input int wr_pct, input int exp_rd, input int exp_wr);
        int wen0;
        int done0;
        int rd0;
        int wr0;
        @(posedge clk);
        wen0  = wen_count;
        done0 = done_count;
        rd0   = rd_steps;
        wr0   = wr_steps;
        incr_pc <= 1'b1;
        @(posedge clk);
        incr_pc <= 1'b0;
        instr   <= word;
        while (done_count == done0) begin
            stall_rd <= chance(rd_pct);
            stall_wr <= chance(wr_pct);
            wr_data  <= $random(seed);
            @(posedge clk);
        end
        stall_rd <= 1'b0;
        stall_wr <= 1'b0;
        // a couple of quiet cycles to catch a late second pulse
        repeat (2) @(posedge clk);
        check_value("wen_itr pulses", wen_count - wen0, 1);
        check_value("done pulses", done_count - done0, 1);
        check_value("write steps", wr_steps - wr0, exp_wr);
        if (exp_rd >= 0) begin
            check_value("read steps", rd_steps - rd0, exp_rd);
        end
    endtask

    initial begin : stimulus
        int hold_wen;
        seed       = 97;
        wen_count  = 0;
        done_count = 0;
        rd_steps   = 0;
        wr_steps   = 0;
        for (int i = 0; i < vec_pkg::rf_depth; i++) begin
            known[i] = 1'b0;
        end
        rst      = 1'b1;
        instr    = make_instr(vec_pkg::op_nop, 8'h00, 8'h00, 8'h00);
        load_pc  = 1'b0;
        incr_pc  = 1'b0;
        stall_rd = 1'b0;
        stall_wr = 1'b0;
        wr_data  = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        set_length(8'd8);
        // load 8 elements at 0x10 and store them back
        run_op(make_instr(vec_pkg::op_vle32, 8'h10, 8'h00, 8'h00), 0, 40, 0, 8);
        run_op(make_instr(vec_pkg::op_vse32, 8'h00, 8'h10, 8'h00), 40, 0, 8, 0);
        // vmacc with vs1 fixed at 0x14 while vs2 and vd walk
        run_op(make_instr(vec_pkg::op_vmacc, 8'h40, 8'h14, 8'h10), 20, 50, -1, 8);
        // held instruction without a pc pulse must stay quiet
        @(posedge clk);
        hold_wen = wen_count;
        repeat (6) @(posedge clk);
        check_value("wen_itr without pc pulse", wen_count - hold_wen, 0);
        run_op(make_instr(vec_pkg::op_vmacc, 8'h40, 8'h14, 8'h10), 30, 30, -1, 8);
        set_length(8'd3);
        run_op(make_instr(vec_pkg::op_vstreamout, 8'h00, 8'h40, 8'h44), 50, 0, 3, 0);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
hw/vec_pkg.sv
hw/vec_op_if.sv
hw/vrf_port_if.sv
hw/vec_decode.sv
hw/auto_incr_vect.sv
hw/vec_regfile.sv
hw/vec_addr_seq_top.sv
verif/tb_vec_addr_seq.sv

/* Bender.yml */
package:
  name: vec_addr_seq

sources:
  - hw/vec_pkg.sv
  - hw/vec_op_if.sv
  - hw/vrf_port_if.sv
  - hw/vec_decode.sv
  - hw/auto_incr_vect.sv
  - hw/vec_regfile.sv
  - hw/vec_addr_seq_top.sv
  - target: test
    files:
      - verif/tb_vec_addr_seq.sv
